// File: hdl/floo_vc_pkg.sv
`default_nettype none

package floo_vc_pkg;

  // output directions of a mesh router plus the local eject port
  // also used to encode the look-ahead route of a flit
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_direction_e;

  // switch allocator history
  // SaHold means the priority pointer moved on the last edge
  typedef enum logic {
    SaIdle = 1'b0,
    SaHold = 1'b1
  } sa_state_e;

  // input ports that compete for one output
  localparam int NumInputs      = 4;
  localparam int NumInputsWidth = 2;

  // downstream vcs, one per next-hop direction except the way back
  localparam int NumVC      = 4;
  localparam int NumVCWidth = 2;

  // credits per downstream vc, the counter must also hold VCDepth itself
  localparam int VCDepth      = 2;
  localparam int VCDepthWidth = 2;

  // flit payload
  localparam int DataWidth = 16;

  // port of the next router through which a flit sent via out_id arrives
  // N->S, E->W, S->N, W->E
  function automatic route_direction_e back_dir(route_direction_e out_id);
    logic [2:0] idx;
    idx = 3'((int'(out_id) + 2) % 4);
    return route_direction_e'(idx);
  endfunction

endpackage

`default_nettype wire

// File: hdl/floo_mux.sv
`timescale 1ns/1ns
`default_nettype none

module floo_mux #(
  parameter int DataWidth = floo_vc_pkg::DataWidth
) (
  input  logic [floo_vc_pkg::NumInputs-1:0]                sel_i,
  input  logic [floo_vc_pkg::NumInputs-1:0][DataWidth-1:0] data_i,
  output logic [DataWidth-1:0]                             data_o
);

  import floo_vc_pkg::*;

  // and-or tree, an all-zero select gives zero
  always_comb begin
    data_o = '0;
    for (int i = 0; i < NumInputs; i++) begin
      data_o |= data_i[i] & {DataWidth{sel_i[i]}};
    end
  end

  // the switch allocator grants at most one input per cycle
  always_comb begin
    assert ($onehot0(sel_i))
      else $error("floo_mux: select %b is not one-hot", sel_i);
  end

endmodule

`default_nettype wire

// File: hdl/floo_sa_global_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module floo_sa_global_arbiter (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [floo_vc_pkg::NumInputs-1:0] req_i,
  input  logic                             commit_i,
  output logic                             gnt_v_o,
  output logic [floo_vc_pkg::NumInputs-1:0] gnt_oh_o
);

  import floo_vc_pkg::*;

  logic [NumInputsWidth-1:0] ptr_q;
  logic [NumInputsWidth-1:0] ptr_d;
  logic [NumInputsWidth-1:0] gnt_idx;
  logic [NumInputsWidth-1:0] scan_idx;
  logic [NumInputsWidth-1:0] last_idx;
  logic                      found;
  sa_state_e                 state_q;
  sa_state_e                 state_d;
  logic [NumInputs-1:0][NumInputsWidth:0] wait_q;

  // first requester at or after the pointer wins
  always_comb begin
    gnt_oh_o = '0;
    gnt_idx  = ptr_q;
    found    = 1'b0;
    scan_idx = ptr_q;
    for (int i = 0; i < NumInputs; i++) begin
      scan_idx = NumInputsWidth'((int'(ptr_q) + i) % NumInputs);
      if (!found && req_i[scan_idx]) begin
        found              = 1'b1;
        gnt_idx            = scan_idx;
        gnt_oh_o[scan_idx] = 1'b1;
      end
    end
  end

  assign gnt_v_o = found;

  // pointer only moves once the grant was turned into a send
  always_comb begin
    ptr_d   = ptr_q;
    state_d = SaIdle;
    if (commit_i && found) begin
      ptr_d   = NumInputsWidth'((int'(gnt_idx) + 1) % NumInputs);
      state_d = SaHold;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q   <= '0;
      state_q <= SaIdle;
    end else begin
      ptr_q   <= ptr_d;
      state_q <= state_d;
    end
  end

  // input that won the last committed grant
  assign last_idx = NumInputsWidth'((int'(ptr_q) + NumInputs - 1) % NumInputs);

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    gnt_v_o |-> $onehot(gnt_oh_o))
    else $error("floo_sa_global_arbiter: grant is not one-hot");

  // right after an advance the last winner has the lowest priority
  a_last_winner: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == SaHold && gnt_oh_o[last_idx]) |-> (req_i == gnt_oh_o))
    else $error("floo_sa_global_arbiter: last winner regranted ahead of others");

  // count commits to other inputs while a request waits
  for (genvar k = 0; k < NumInputs; k++) begin : gen_fairness
    always_ff @(posedge clk_i) begin
      if (reset_i || !req_i[k] || (commit_i && gnt_oh_o[k])) begin
        wait_q[k] <= '0;
      end else if (commit_i && gnt_v_o) begin
        wait_q[k] <= wait_q[k] + 1'b1;
      end
    end

    a_no_starvation: assert property (@(posedge clk_i) disable iff (reset_i)
      req_i[k] |-> (wait_q[k] < (NumInputsWidth + 1)'(NumInputs)))
      else $error("floo_sa_global_arbiter: input %0d passed over too often", k);
  end

endmodule

`default_nettype wire

// File: hdl/floo_vc_selection.sv
`timescale 1ns/1ns
`default_nettype none

module floo_vc_selection #(
  parameter floo_vc_pkg::route_direction_e OutputId = floo_vc_pkg::East
) (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic                                                    credit_v_i,
  input  logic [floo_vc_pkg::NumVCWidth-1:0]                      credit_id_i,
  input  logic                                                    consume_v_i,
  input  logic [floo_vc_pkg::NumVCWidth-1:0]                      consume_id_i,
  output logic [floo_vc_pkg::NumVC-1:0]                           vc_selection_v_o,
  output logic [floo_vc_pkg::NumVC-1:0][floo_vc_pkg::NumVCWidth-1:0] vc_selection_id_o
);

  import floo_vc_pkg::*;

  logic [NumVC-1:0][VCDepthWidth-1:0] credit_q;
  logic [NumVC-1:0][VCDepthWidth-1:0] credit_d;
  logic [NumVC-1:0]                   returned;
  logic [NumVC-1:0]                   consumed;
  logic [NumVC-1:0]                   has_credit;
  logic [NumVCWidth-1:0]              fallback_id;

  // the eject port has its own single vc and is not served here
  if (OutputId == Eject) begin : gen_bad_output
    $error("floo_vc_selection: OutputId must be North, East, South or West");
  end

  // saturating credit counters
  // a return and a consume on the same vc cancel out
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      returned[v]   = credit_v_i && (credit_id_i == NumVCWidth'(v));
      consumed[v]   = consume_v_i && (consume_id_i == NumVCWidth'(v));
      has_credit[v] = (credit_q[v] != '0);
      credit_d[v]   = credit_q[v];
      if (returned[v] && !consumed[v] && credit_q[v] != VCDepthWidth'(VCDepth)) begin
        credit_d[v] = credit_q[v] + 1'b1;
      end else if (consumed[v] && !returned[v] && has_credit[v]) begin
        credit_d[v] = credit_q[v] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_q[v] <= VCDepthWidth'(VCDepth);
      end
    end else begin
      credit_q <= credit_d;
    end
  end

  // lowest-index vc that still has room downstream
  always_comb begin
    fallback_id = '0;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (has_credit[v]) begin
        fallback_id = NumVCWidth'(v);
      end
    end
  end

  // preferred vc p when it has credit, otherwise the fallback
  for (genvar p = 0; p < NumVC; p++) begin : gen_select
    assign vc_selection_v_o[p]  = |has_credit;
    assign vc_selection_id_o[p] = has_credit[p] ? NumVCWidth'(p) : fallback_id;
  end

  for (genvar v = 0; v < NumVC; v++) begin : gen_bound_check
    a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
      credit_q[v] <= VCDepthWidth'(VCDepth))
      else $error("floo_vc_selection: vc %0d holds more than VCDepth credits", v);
  end

  a_no_empty_consume: assert property (@(posedge clk_i) disable iff (reset_i)
    consume_v_i |-> (credit_q[consume_id_i] != '0))
    else $error("floo_vc_selection: flit sent on vc %0d without credit", consume_id_i);

endmodule

`default_nettype wire

// File: hdl/floo_vc_assignment.sv
`timescale 1ns/1ns
`default_nettype none

module floo_vc_assignment #(
  parameter floo_vc_pkg::route_direction_e OutputId = floo_vc_pkg::East
) (
  input  logic                                                    sa_global_v_i,
  input  logic [floo_vc_pkg::NumInputs-1:0]                       sa_global_input_dir_oh_i,
  input  floo_vc_pkg::route_direction_e [floo_vc_pkg::NumInputs-1:0] look_ahead_routing_i,
  // per preferred vc index, was a vc found and which one
  input  logic [floo_vc_pkg::NumVC-1:0]                           vc_selection_v_i,
  input  logic [floo_vc_pkg::NumVC-1:0][floo_vc_pkg::NumVCWidth-1:0] vc_selection_id_i,
  output logic                                                    vc_assignment_v_o,
  output logic [floo_vc_pkg::NumVCWidth-1:0]                      vc_assignment_id_o,
  output floo_vc_pkg::route_direction_e                           look_ahead_routing_sel_o
);

  import floo_vc_pkg::*;

  logic [$bits(route_direction_e)-1:0] look_ahead_raw;
  route_direction_e                    look_ahead_sel;
  route_direction_e                    back_direction;
  logic [NumVCWidth-1:0]               preferred_id;

  if (OutputId == Eject) begin : gen_bad_output
    $error("floo_vc_assignment: OutputId must be North, East, South or West");
  end

  // look-ahead route of the granted flit
  floo_mux #(
    .DataWidth($bits(route_direction_e))
  ) i_floo_mux_look_ahead (
    .sel_i  (sa_global_input_dir_oh_i),
    .data_i (look_ahead_routing_i),
    .data_o (look_ahead_raw)
  );

  assign look_ahead_sel           = route_direction_e'(look_ahead_raw);
  assign look_ahead_routing_sel_o = look_ahead_sel;

  // port on the next router that faces back toward this one
  assign back_direction = back_dir(OutputId);

  // the downstream router keeps no vc for the way back
  // so directions above it shift down by one
  // e.g. for East: N->0, E->1, S->2, Eject->3
  assign preferred_id = (look_ahead_raw > back_direction) ?
                        NumVCWidth'(look_ahead_raw - 3'd1) :
                        NumVCWidth'(look_ahead_raw);

  assign vc_assignment_v_o  = sa_global_v_i & vc_selection_v_i[preferred_id];
  assign vc_assignment_id_o = vc_selection_id_i[preferred_id];

  // a flit must never turn around at the next hop
  always_comb begin
    if (sa_global_v_i) begin
      assert (look_ahead_sel != back_direction)
        else $error("floo_vc_assignment: granted flit routes back to %0d", OutputId);
    end
  end

endmodule

`default_nettype wire

// File: hdl/floo_vc_output_port.sv
`timescale 1ns/1ns
`default_nettype none

module floo_vc_output_port #(
  parameter floo_vc_pkg::route_direction_e OutputId = floo_vc_pkg::East
) (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [floo_vc_pkg::NumInputs-1:0]                       in_req_i,
  input  floo_vc_pkg::route_direction_e [floo_vc_pkg::NumInputs-1:0] in_dir_i,
  input  logic [floo_vc_pkg::NumInputs-1:0][floo_vc_pkg::DataWidth-1:0] in_data_i,
  output logic [floo_vc_pkg::NumInputs-1:0]                       in_ack_o,
  input  logic                                                    credit_v_i,
  input  logic [floo_vc_pkg::NumVCWidth-1:0]                      credit_id_i,
  output logic                                                    out_valid_o,
  output logic [floo_vc_pkg::NumVCWidth-1:0]                      out_vc_id_o,
  output floo_vc_pkg::route_direction_e                           out_dir_o,
  output logic [floo_vc_pkg::DataWidth-1:0]                       out_data_o
);

  import floo_vc_pkg::*;

  logic [NumInputs-1:0]             ack_q;
  logic [NumInputs-1:0]             eligible;
  logic                             sa_global_v;
  logic [NumInputs-1:0]             sa_global_input_dir_oh;
  logic [NumVC-1:0]                 vc_selection_v;
  logic [NumVC-1:0][NumVCWidth-1:0] vc_selection_id;
  logic                             vc_assignment_v;
  logic [NumVCWidth-1:0]            vc_assignment_id;
  route_direction_e                 look_ahead_sel;
  logic [DataWidth-1:0]             data_sel;

  // a request counts until its ack is up
  assign eligible = in_req_i & ~ack_q;
  assign in_ack_o = ack_q;

  floo_sa_global_arbiter i_sa_global (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (eligible),
    .commit_i (vc_assignment_v),
    .gnt_v_o  (sa_global_v),
    .gnt_oh_o (sa_global_input_dir_oh)
  );

  floo_vc_assignment #(
    .OutputId(OutputId)
  ) i_vc_assignment (
    .sa_global_v_i            (sa_global_v),
    .sa_global_input_dir_oh_i (sa_global_input_dir_oh),
    .look_ahead_routing_i     (in_dir_i),
    .vc_selection_v_i         (vc_selection_v),
    .vc_selection_id_i        (vc_selection_id),
    .vc_assignment_v_o        (vc_assignment_v),
    .vc_assignment_id_o       (vc_assignment_id),
    .look_ahead_routing_sel_o (look_ahead_sel)
  );

  floo_vc_selection #(
    .OutputId(OutputId)
  ) i_vc_selection (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .credit_v_i        (credit_v_i),
    .credit_id_i       (credit_id_i),
    .consume_v_i       (vc_assignment_v),
    .consume_id_i      (vc_assignment_id),
    .vc_selection_v_o  (vc_selection_v),
    .vc_selection_id_o (vc_selection_id)
  );

  floo_mux #(
    .DataWidth(DataWidth)
  ) i_floo_mux_data (
    .sel_i  (sa_global_input_dir_oh),
    .data_i (in_data_i),
    .data_o (data_sel)
  );

  // ack rises with the sent flit and falls once req has dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q       <= '0;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= vc_assignment_v;
      for (int k = 0; k < NumInputs; k++) begin
        if (vc_assignment_v && sa_global_input_dir_oh[k]) begin
          ack_q[k] <= 1'b1;
        end else if (!in_req_i[k]) begin
          ack_q[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (vc_assignment_v) begin
      out_vc_id_o <= vc_assignment_id;
      out_dir_o   <= look_ahead_sel;
      out_data_o  <= data_sel;
    end
  end

endmodule

`default_nettype wire

// File: test/floo_vc_output_port_checker.sv
`timescale 1ns/1ns
`default_nettype none

module floo_vc_output_port_checker #(
  parameter floo_vc_pkg::route_direction_e OutputId = floo_vc_pkg::East
) (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  input  logic [floo_vc_pkg::NumInputs-1:0]                             in_req_i,
  input  floo_vc_pkg::route_direction_e [floo_vc_pkg::NumInputs-1:0]    in_dir_i,
  input  logic [floo_vc_pkg::NumInputs-1:0][floo_vc_pkg::DataWidth-1:0] in_data_i,
  input  logic [floo_vc_pkg::NumInputs-1:0]                             in_ack_i,
  input  logic                                                          credit_v_i,
  input  logic [floo_vc_pkg::NumVCWidth-1:0]                            credit_id_i,
  input  logic                                                          out_valid_i,
  input  logic [floo_vc_pkg::NumVCWidth-1:0]                            out_vc_id_i,
  input  floo_vc_pkg::route_direction_e                                 out_dir_i,
  input  logic [floo_vc_pkg::DataWidth-1:0]                             out_data_i,
  output int                                                            value_errors_o,
  output int                                                            protocol_errors_o,
  output int                                                            delivered_o
);

  import floo_vc_pkg::*;

  // credit mirror of the downstream vcs, as it stood before the current consume
  int                   credit_mirror [NumVC];
  logic                 pending_return;
  logic [NumVCWidth-1:0] pending_id;
  logic [NumInputs-1:0] prev_req;
  logic [NumInputs-1:0] prev_ack;
  // flit each requester offered when its req rose
  route_direction_e     flit_dir [NumInputs];
  logic [DataWidth-1:0] flit_data [NumInputs];
  logic [NumInputs-1:0] flit_open;
  int                   wait_count [NumInputs];
  int                   sends_since_return;
  logic                 idle_check;
  int                   value_errors = 0;
  int                   protocol_errors = 0;
  int                   delivered = 0;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;
  assign delivered_o       = delivered;

  // vc that the output must pick for a flit heading to dir
  function automatic int expected_vc(route_direction_e dir, logic [NumVC-1:0] nonzero);
    int back;
    int pref;
    back = (int'(OutputId) + 2) % 4;
    pref = (int'(dir) > back) ? int'(dir) - 1 : int'(dir);
    if (nonzero[pref]) begin
      return pref;
    end
    for (int v = 0; v < NumVC; v++) begin
      if (nonzero[v]) begin
        return v;
      end
    end
    return -1;
  endfunction

  task automatic value_mismatch(string msg);
    value_errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic protocol_violation(string msg);
    protocol_errors++;
    $display("handshake violation at %0t ns: %s", $time, msg);
  endtask

  // compare the sent flit with the one offered by the input whose ack rose
  task automatic check_delivery(int k);
    if (!flit_open[k]) begin
      protocol_violation($sformatf("input %0d acked twice for one flit", k));
    end
    if (out_dir_i != flit_dir[k] || out_data_i != flit_data[k]) begin
      value_mismatch($sformatf("input %0d sent dir %0d data %h, offered dir %0d data %h",
                               k, out_dir_i, out_data_i, flit_dir[k], flit_data[k]));
    end
    flit_open[k] = 1'b0;
    delivered++;
    // inputs that were eligible while another one won
    for (int j = 0; j < NumInputs; j++) begin
      if (j == k || !prev_req[j] || prev_ack[j]) begin
        wait_count[j] = 0;
      end else begin
        wait_count[j]++;
        if (wait_count[j] > NumInputs) begin
          protocol_violation($sformatf("input %0d passed over %0d times", j, wait_count[j]));
        end
      end
    end
  endtask

  always @(negedge clk_i) begin : sample
    logic [NumInputs-1:0] ack_rise;
    logic [NumVC-1:0]     nonzero;
    int                   exp_id;
    int                   winner;
    if (reset_i) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_mirror[v] = VCDepth;
      end
      for (int k = 0; k < NumInputs; k++) begin
        wait_count[k] = 0;
      end
      flit_open          = '0;
      prev_req           = '0;
      prev_ack           = '0;
      pending_return     = 1'b0;
      pending_id         = '0;
      sends_since_return = 0;
      idle_check         = 1'b1;
    end else begin
      ack_rise = in_ack_i & ~prev_ack;
      winner   = -1;
      if (idle_check) begin
        if (out_valid_i || in_ack_i != '0) begin
          protocol_violation("output valid or an ack is high right after reset");
        end
        idle_check = 1'b0;
      end
      for (int k = 0; k < NumInputs; k++) begin
        if (ack_rise[k] && !prev_req[k]) begin
          protocol_violation($sformatf("ack %0d rose while req was low", k));
        end
        if (!in_ack_i[k] && prev_ack[k] && prev_req[k]) begin
          protocol_violation($sformatf("ack %0d fell before req dropped", k));
        end
        if (ack_rise[k]) begin
          winner = k;
        end
        if (in_req_i[k] && !prev_req[k]) begin
          if (flit_open[k]) begin
            protocol_violation($sformatf("input %0d raised req before its flit was sent", k));
          end
          flit_open[k] = 1'b1;
          flit_dir[k]  = in_dir_i[k];
          flit_data[k] = in_data_i[k];
        end
      end
      if (pending_return) begin
        sends_since_return = 0;
      end
      if (out_valid_i) begin
        for (int v = 0; v < NumVC; v++) begin
          nonzero[v] = (credit_mirror[v] != 0);
        end
        exp_id = expected_vc(out_dir_i, nonzero);
        if (exp_id < 0) begin
          value_mismatch("flit sent while no vc had credit");
        end else if (int'(out_vc_id_i) != exp_id) begin
          value_mismatch($sformatf("dir %0d sent on vc %0d, expected vc %0d",
                                   out_dir_i, out_vc_id_i, exp_id));
        end
        sends_since_return++;
        if (sends_since_return > NumVC * VCDepth) begin
          value_mismatch("more flits sent than credits held downstream");
        end
        if (credit_mirror[out_vc_id_i] > 0) begin
          credit_mirror[out_vc_id_i]--;
        end
        if (!$onehot(ack_rise)) begin
          protocol_violation($sformatf("%0d acks rose with one flit", $countones(ack_rise)));
        end else begin
          check_delivery(winner);
        end
      end else if (ack_rise != '0) begin
        protocol_violation("ack rose with no flit on the output");
      end
      // returns land one edge after they are seen
      if (pending_return) begin
        if (credit_mirror[pending_id] >= VCDepth) begin
          value_mismatch($sformatf("credit returned to full vc %0d", pending_id));
        end else begin
          credit_mirror[pending_id]++;
        end
      end
      pending_return = credit_v_i;
      pending_id     = credit_id_i;
      prev_req       = in_req_i;
      prev_ack       = in_ack_i;
    end
  end

endmodule

`default_nettype wire

// File: test/floo_vc_output_port_tb.sv
`timescale 1ns/1ns
`default_nettype none

module floo_vc_output_port_tb;

  import floo_vc_pkg::*;

  localparam route_direction_e OutputId = East;
  localparam int NumFlits       = 40;
  localparam int Seed           = 11999;
  localparam int MaxReturnDelay = 6;
  localparam int WithholdStart  = 80;
  localparam int WithholdCycles = 30;
  localparam int TimeoutNs      = (NumInputs * NumFlits * 20 + 200) * 4;

  typedef enum logic [1:0] {
    ReqIdle,
    ReqWaitAck,
    ReqWaitDrop
  } req_state_e;

  logic                                clk;
  logic                                reset;
  logic [NumInputs-1:0]                in_req;
  route_direction_e [NumInputs-1:0]    in_dir;
  logic [NumInputs-1:0][DataWidth-1:0] in_data;
  logic [NumInputs-1:0]                in_ack;
  logic                                credit_v;
  logic [NumVCWidth-1:0]               credit_id;
  logic                                out_valid;
  logic [NumVCWidth-1:0]               out_vc_id;
  route_direction_e                    out_dir;
  logic [DataWidth-1:0]                out_data;
  int                                  value_errors;
  int                                  protocol_errors;
  int                                  delivered;

  req_state_e req_state [NumInputs];
  int         sent [NumInputs];
  int         gap [NumInputs];
  int         cycle;
  // consumed credits waiting to come back, with the cycle they are due
  int         ret_vc [$];
  int         ret_due [$];

  floo_vc_output_port #(
    .OutputId(OutputId)
  ) dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .in_req_i    (in_req),
    .in_dir_i    (in_dir),
    .in_data_i   (in_data),
    .in_ack_o    (in_ack),
    .credit_v_i  (credit_v),
    .credit_id_i (credit_id),
    .out_valid_o (out_valid),
    .out_vc_id_o (out_vc_id),
    .out_dir_o   (out_dir),
    .out_data_o  (out_data)
  );

  floo_vc_output_port_checker #(
    .OutputId(OutputId)
  ) i_checker (
    .clk_i             (clk),
    .reset_i           (reset),
    .in_req_i          (in_req),
    .in_dir_i          (in_dir),
    .in_data_i         (in_data),
    .in_ack_i          (in_ack),
    .credit_v_i        (credit_v),
    .credit_id_i       (credit_id),
    .out_valid_i       (out_valid),
    .out_vc_id_i       (out_vc_id),
    .out_dir_i         (out_dir),
    .out_data_i        (out_data),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors),
    .delivered_o       (delivered)
  );

  always #2 clk = ~clk;

  // any direction except the one leading back here
  function automatic route_direction_e legal_direction(int unsigned r);
    int back;
    int d;
    back = (int'(OutputId) + 2) % 4;
    d    = int'(r % 4);
    if (d >= back) begin
      d = d + 1;
    end
    return route_direction_e'(3'(d));
  endfunction

  function automatic bit all_sent();
    for (int k = 0; k < NumInputs; k++) begin
      if (sent[k] < NumFlits) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // one four-phase step per requester and cycle
  task automatic step_requesters();
    for (int k = 0; k < NumInputs; k++) begin
      case (req_state[k])
        ReqIdle: begin
          if (sent[k] < NumFlits && gap[k] > 0) begin
            gap[k]--;
          end else if (sent[k] < NumFlits) begin
            in_dir[k]    = legal_direction($urandom);
            in_data[k]   = DataWidth'($urandom);
            in_req[k]    = 1'b1;
            req_state[k] = ReqWaitAck;
          end
        end
        ReqWaitAck: begin
          if (in_ack[k]) begin
            in_req[k]    = 1'b0;
            req_state[k] = ReqWaitDrop;
          end
        end
        default: begin
          if (!in_ack[k]) begin
            sent[k]++;
            gap[k]       = $urandom % 3;
            req_state[k] = ReqIdle;
          end
        end
      endcase
    end
  endtask

  // downstream router frees each slot after a short random delay
  task automatic step_credit_return();
    int found;
    found = -1;
    if (out_valid) begin
      ret_vc.push_back(int'(out_vc_id));
      ret_due.push_back(cycle + int'($urandom % (MaxReturnDelay + 1)));
    end
    credit_v = 1'b0;
    if (cycle < WithholdStart || cycle >= WithholdStart + WithholdCycles) begin
      for (int i = 0; i < ret_due.size(); i++) begin
        if (found < 0 && ret_due[i] <= cycle) begin
          found = i;
        end
      end
      if (found >= 0) begin
        credit_v  = 1'b1;
        credit_id = NumVCWidth'(ret_vc[found]);
        ret_vc.delete(found);
        ret_due.delete(found);
      end
    end
  endtask

  initial begin
    void'($urandom(Seed));
    clk       = 1'b0;
    reset     = 1'b1;
    in_req    = '0;
    in_data   = '0;
    credit_v  = 1'b0;
    credit_id = '0;
    cycle     = 0;
    for (int k = 0; k < NumInputs; k++) begin
      in_dir[k]    = North;
      req_state[k] = ReqIdle;
      sent[k]      = 0;
      gap[k]       = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    while (!all_sent()) begin
      @(posedge clk);
      #1;
      cycle++;
      step_requesters();
      step_credit_return();
    end
    repeat (10) @(posedge clk);
    $display("value errors %0d, protocol errors %0d, flits delivered %0d of %0d",
             value_errors, protocol_errors, delivered, NumInputs * NumFlits);
    if (value_errors == 0 && protocol_errors == 0 && delivered == NumInputs * NumFlits) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TimeoutNs);
    $display("timeout after %0d ns with requests still open", TimeoutNs);
    for (int k = 0; k < NumInputs; k++) begin
      if (sent[k] < NumFlits) begin
        $display("requester %0d unfinished, %0d of %0d flits sent", k, sent[k], NumFlits);
      end
    end
    $display("value errors %0d, protocol errors %0d, flits delivered %0d of %0d",
             value_errors, protocol_errors, delivered, NumInputs * NumFlits);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: floo_vc_output_port.f
hdl/floo_vc_pkg.sv
hdl/floo_mux.sv
hdl/floo_sa_global_arbiter.sv
hdl/floo_vc_selection.sv
hdl/floo_vc_assignment.sv
hdl/floo_vc_output_port.sv
test/floo_vc_output_port_checker.sv
test/floo_vc_output_port_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the floo_vc_output_port testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module floo_vc_output_port_tb \
       -f floo_vc_output_port.f \
       -o floo_vc_output_port_sim \
       > build.log 2>&1 \
  && ./obj_dir/floo_vc_output_port_sim > sim.log 2>&1

# the run counts as good only if the log holds the pass line
grep -q "^SIMULATION PASSED$" sim.log \
  && echo "test passed" \
  || { echo "test failed, see build.log and sim.log"; exit 1; }
